// File: design/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
    parameter int COUNT_WIDTH = 21
) (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    // processor side
    input  wire logic                  cpu_valid,
    input  wire cache_pkg::cpu_req_t   cpu_req,
    output logic                       cpu_ready,
    output cache_pkg::word_t           cpu_rdata,
    // memory side
    output logic                       mem_valid,
    output cache_pkg::mem_req_t        mem_req,
    input  wire logic                  mem_ready,
    input  wire cache_pkg::word_t      mem_rdata,
    // tag store
    output cache_pkg::index_t          ts_index,
    output cache_pkg::tag_t            ts_tag,
    input  wire logic                  hit,
    input  wire cache_pkg::way_t       hit_way,
    input  wire cache_pkg::way_t       victim_way,
    input  wire cache_pkg::tag_t       victim_tag,
    input  wire logic                  victim_valid,
    input  wire logic                  victim_dirty,
    output logic                       touch,
    output logic                       fill,
    output logic                       set_dirty,
    output logic                       clean,
    output cache_pkg::way_t            upd_way,
    // data store
    output cache_pkg::index_t          ds_index,
    output cache_pkg::way_t            ds_way,
    output cache_pkg::word_sel_t       ds_word_sel,
    input  wire cache_pkg::word_t      ds_rdata,
    output logic                       ds_we,
    output cache_pkg::word_t           ds_wdata,
    // statistics
    output logic [COUNT_WIDTH-1:0]     hits,
    output logic [COUNT_WIDTH-1:0]     misses
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::cpu_req_t    req;      // latched request
    cache_pkg::way_t        way_q;    // hit way or victim
    cache_pkg::word_sel_t   word_cnt; // block word being moved
    cache_pkg::word_sel_t   req_word;

    logic mem_xfer;
    logic last_word;
    logic in_access;

    assign ts_index  = req.addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
    assign ts_tag    = req.addr[31 -: cache_pkg::TAG_BITS];
    assign req_word  = req.addr[cache_pkg::OFFSET_BITS-1 -: $bits(cache_pkg::word_sel_t)];

    assign mem_xfer  = mem_valid && mem_ready;
    assign last_word = word_cnt == cache_pkg::word_sel_t'(cache_pkg::WORDS_PER_BLOCK - 1);
    assign in_access = state == cache_pkg::ST_ACCESS;

    assign upd_way   = way_q;
    assign touch     = in_access;
    assign set_dirty = in_access && req.write;
    assign clean     = state == cache_pkg::ST_EVICT && mem_xfer && last_word;
    assign fill      = state == cache_pkg::ST_REFILL && mem_xfer && last_word;

    assign ds_index    = ts_index;
    assign ds_way      = way_q;
    assign ds_word_sel = in_access ? req_word : word_cnt;
    assign ds_we       = (state == cache_pkg::ST_REFILL && mem_xfer) || set_dirty;
    assign ds_wdata    = in_access ? req.wdata : mem_rdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= cache_pkg::ST_IDLE;
            cpu_ready <= 1'b0;
            mem_valid <= 1'b0;
            word_cnt  <= '0;
            hits      <= '0;
            misses    <= '0;
        end else begin
            cpu_ready <= 1'b0;
            case (state)
                cache_pkg::ST_IDLE: begin
                    if (cpu_valid && !cpu_ready) begin // skip the acked request
                        state <= cache_pkg::ST_LOOKUP;
                    end
                end
                cache_pkg::ST_LOOKUP: begin
                    word_cnt <= '0;
                    if (hit) begin
                        hits  <= hits + 1'b1;
                        state <= cache_pkg::ST_ACCESS;
                    end else begin
                        misses <= misses + 1'b1;
                        if (victim_valid && victim_dirty) begin
                            state <= cache_pkg::ST_EVICT;
                        end else begin
                            state <= cache_pkg::ST_REFILL;
                        end
                    end
                end
                cache_pkg::ST_EVICT, cache_pkg::ST_REFILL: begin
                    // one word per handshake, valid low for a cycle in between
                    if (!mem_valid) begin
                        mem_valid <= 1'b1;
                    end else if (mem_ready) begin
                        mem_valid <= 1'b0;
                        word_cnt  <= word_cnt + 1'b1;
                        if (last_word) begin
                            if (state == cache_pkg::ST_EVICT) begin
                                state <= cache_pkg::ST_REFILL;
                            end else begin
                                state <= cache_pkg::ST_ACCESS;
                            end
                        end
                    end
                end
                cache_pkg::ST_ACCESS: begin
                    cpu_ready <= 1'b1;
                    state     <= cache_pkg::ST_IDLE;
                end
                default: state <= cache_pkg::ST_IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == cache_pkg::ST_IDLE) begin
            req <= cpu_req;
        end
        if (state == cache_pkg::ST_LOOKUP) begin
            way_q <= hit ? hit_way : victim_way;
        end
        if (state == cache_pkg::ST_EVICT && !mem_valid) begin
            mem_req.addr  <= cache_pkg::addr_t'({victim_tag, ts_index, word_cnt, 2'b00});
            mem_req.wdata <= ds_rdata;
            mem_req.write <= 1'b1;
        end
        if (state == cache_pkg::ST_REFILL && !mem_valid) begin
            mem_req.addr  <= cache_pkg::addr_t'({ts_tag, ts_index, word_cnt, 2'b00});
            mem_req.wdata <= '0;
            mem_req.write <= 1'b0;
        end
        if (in_access && !req.write) begin
            cpu_rdata <= ds_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry
    localparam int WAYS            = 4;
    localparam int BLOCK_BYTES     = 8;
    localparam int CACHE_BYTES     = 1024;
    localparam int WORDS_PER_BLOCK = BLOCK_BYTES / 4;
    localparam int SETS            = CACHE_BYTES / (BLOCK_BYTES * WAYS);
    localparam int OFFSET_BITS     = $clog2(BLOCK_BYTES);
    localparam int INDEX_BITS      = $clog2(SETS);
    localparam int TAG_BITS        = 32 - INDEX_BITS - OFFSET_BITS;

    typedef logic [31:0]                          word_t;
    typedef logic [31:0]                          addr_t;
    typedef logic [TAG_BITS-1:0]                  tag_t;
    typedef logic [INDEX_BITS-1:0]                index_t;
    typedef logic [$clog2(WORDS_PER_BLOCK)-1:0]   word_sel_t;
    typedef logic [$clog2(WAYS)-1:0]              way_t;
    typedef logic [$clog2(WAYS)-1:0]              age_t; // 0 newest, WAYS-1 is the victim

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } cpu_req_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT,
        ST_REFILL,
        ST_ACCESS
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int COUNT_WIDTH = 21
) (
    input  wire logic                clk,
    input  wire logic                resetn,
    input  wire logic                cpu_valid,
    input  wire cache_pkg::cpu_req_t cpu_req,
    output logic                     cpu_ready,
    output cache_pkg::word_t         cpu_rdata,
    output logic                     mem_valid,
    output cache_pkg::mem_req_t      mem_req,
    input  wire logic                mem_ready,
    input  wire cache_pkg::word_t    mem_rdata,
    output logic [COUNT_WIDTH-1:0]   hits,
    output logic [COUNT_WIDTH-1:0]   misses
);

    cache_pkg::index_t    ts_index;
    cache_pkg::tag_t      ts_tag;
    logic                 hit;
    cache_pkg::way_t      hit_way;
    cache_pkg::way_t      victim_way;
    cache_pkg::tag_t      victim_tag;
    logic                 victim_valid;
    logic                 victim_dirty;
    logic                 touch;
    logic                 fill;
    logic                 set_dirty;
    logic                 clean;
    cache_pkg::way_t      upd_way;
    cache_pkg::index_t    ds_index;
    cache_pkg::way_t      ds_way;
    cache_pkg::word_sel_t ds_word_sel;
    cache_pkg::word_t     ds_rdata;
    logic                 ds_we;
    cache_pkg::word_t     ds_wdata;

    cache_ctrl #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_ctrl (
        .clk, .resetn,
        .cpu_valid, .cpu_req, .cpu_ready, .cpu_rdata,
        .mem_valid, .mem_req, .mem_ready, .mem_rdata,
        .ts_index, .ts_tag,
        .hit, .hit_way, .victim_way, .victim_tag, .victim_valid, .victim_dirty,
        .touch, .fill, .set_dirty, .clean, .upd_way,
        .ds_index, .ds_way, .ds_word_sel, .ds_rdata, .ds_we, .ds_wdata,
        .hits, .misses
    );

    tag_store u_tags (
        .clk, .resetn,
        .index(ts_index), .tag(ts_tag),
        .hit, .hit_way, .victim_way, .victim_tag, .victim_valid, .victim_dirty,
        .touch, .fill, .set_dirty, .clean, .upd_way
    );

    data_store u_data (
        .clk,
        .index(ds_index), .way(ds_way), .word_sel(ds_word_sel),
        .rdata(ds_rdata), .we(ds_we), .wdata(ds_wdata)
    );

endmodule

`default_nettype wire

// File: design/data_store.sv
`default_nettype none

module data_store (
    input  wire logic                 clk,
    input  wire cache_pkg::index_t    index,
    input  wire cache_pkg::way_t      way,
    input  wire cache_pkg::word_sel_t word_sel,
    output cache_pkg::word_t          rdata,
    input  wire logic                 we,
    input  wire cache_pkg::word_t     wdata
);

    cache_pkg::word_t
        words [cache_pkg::SETS][cache_pkg::WAYS][cache_pkg::WORDS_PER_BLOCK];

    assign rdata = words[index][way][word_sel]; // async read

    always_ff @(posedge clk) begin
        if (we) begin
            words[index][way][word_sel] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: design/tag_store.sv
`default_nettype none

module tag_store (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire cache_pkg::index_t index,
    input  wire cache_pkg::tag_t   tag,
    output logic                   hit,
    output cache_pkg::way_t        hit_way,
    output cache_pkg::way_t        victim_way,
    output cache_pkg::tag_t        victim_tag,
    output logic                   victim_valid,
    output logic                   victim_dirty,
    input  wire logic              touch,
    input  wire logic              fill,
    input  wire logic              set_dirty,
    input  wire logic              clean,
    input  wire cache_pkg::way_t   upd_way
);

    cache_pkg::tag_t tags  [cache_pkg::SETS][cache_pkg::WAYS];
    cache_pkg::age_t ages  [cache_pkg::SETS][cache_pkg::WAYS];
    logic            valid [cache_pkg::SETS][cache_pkg::WAYS];
    logic            dirty [cache_pkg::SETS][cache_pkg::WAYS];

    cache_pkg::age_t old_age;

    // parallel compare over the set
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (valid[index][w] && tags[index][w] == tag) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
            if (ages[index][w] == cache_pkg::age_t'(cache_pkg::WAYS - 1)) begin
                victim_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign victim_tag   = tags[index][victim_way];
    assign victim_valid = valid[index][victim_way];
    assign victim_dirty = dirty[index][victim_way];

    assign old_age = ages[index][upd_way];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                    ages[s][w]  <= cache_pkg::age_t'(w); // way 3 goes first
                end
            end
        end else begin
            if (touch) begin
                // younger ways age by one, so ages stay a permutation
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    if (cache_pkg::way_t'(w) == upd_way) begin
                        ages[index][w] <= '0;
                    end else if (ages[index][w] < old_age) begin
                        ages[index][w] <= ages[index][w] + 1'b1;
                    end
                end
            end
            if (fill) begin
                valid[index][upd_way] <= 1'b1;
                dirty[index][upd_way] <= 1'b0;
            end
            if (set_dirty) begin
                dirty[index][upd_way] <= 1'b1;
            end
            if (clean) begin
                dirty[index][upd_way] <= 1'b0;
            end
        end
    end

    // tag payload
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index][upd_way] <= tag;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache -f sim.f -o tb_cache_sim
./obj_dir/tb_cache_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim.f
design/cache_pkg.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
test/mem_model.sv
test/tb_cache.sv

// File: test/mem_model.sv
`default_nettype none

module mem_model #(
    parameter cache_pkg::word_t FILL = 32'h5a3c_96e1
) (
    input  wire logic                clk,
    input  wire logic                resetn,
    input  wire logic [3:0]          max_delay,
    input  wire logic                mem_valid,
    input  wire cache_pkg::mem_req_t mem_req,
    output logic                     mem_ready,
    output cache_pkg::word_t         mem_rdata,
    output int                       log_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    cache_pkg::word_t store [cache_pkg::addr_t]; // written words, keyed by word address
    logic             ready_q   = 1'b0;
    cache_pkg::word_t rdata_q   = '0;
    int               errors_q  = 0;
    int unsigned      wait_cnt  = 0;
    logic             busy      = 1'b0;
    logic             half      = 1'b0; // first word of a write-back seen
    cache_pkg::addr_t pair_addr = '0;
    cache_pkg::addr_t word_addr;

    assign mem_ready  = ready_q;
    assign mem_rdata  = rdata_q;
    assign log_errors = errors_q;
    assign word_addr  = mem_req.addr >> 2;

    always @(posedge clk) begin
        ready_q <= 1'b0;
        if (!resetn) begin
            busy <= 1'b0;
            half <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                ready_q <= 1'b1;
                busy    <= 1'b0;
                if (mem_req.write) begin
                    store[word_addr] = mem_req.wdata;
                    // write-backs come as word 0 then word 1 of one block
                    if (!half) begin
                        half      <= 1'b1;
                        pair_addr <= mem_req.addr;
                        if (mem_req.addr[cache_pkg::OFFSET_BITS-1:2] != '0) begin
                            errors_q <= errors_q + 1;
                            $display("Error at %0t ns: write-back starts at %h, not word 0",
                                     $time, mem_req.addr);
                        end
                    end else begin
                        half <= 1'b0;
                        if (mem_req.addr != pair_addr + 32'd4) begin
                            errors_q <= errors_q + 1;
                            $display("Error at %0t ns: write-back word %h does not follow %h",
                                     $time, mem_req.addr, pair_addr);
                        end
                    end
                end else begin
                    rdata_q <= store.exists(word_addr) ? store[word_addr] : word_addr ^ FILL;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_valid && !ready_q) begin
            wait_cnt <= $urandom_range(32'(max_delay), 0);
            busy     <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_cache.sv
`default_nettype none

module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int               COUNT_WIDTH = 21;
    localparam int               CLK_PERIOD  = 100;
    localparam int               HIT_EDGES   = 3; // ready seen 3 edges after valid is sampled
    localparam cache_pkg::word_t FILL        = 32'h5a3c_96e1;
    localparam int               N_RANDOM    = 300;
    localparam int               N_REPEAT    = 40; // address pairs
    localparam int               N_SLOW      = 60;
    localparam int               N_REQ       = N_RANDOM + 2 * N_REPEAT + 6 + N_SLOW;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    logic                clk       = 1'b0;
    logic                resetn    = 1'b0;
    logic                cpu_valid = 1'b0;
    cache_pkg::cpu_req_t cpu_req   = '0;
    logic                cpu_ready;
    cache_pkg::word_t    cpu_rdata;
    logic                mem_valid;
    cache_pkg::mem_req_t mem_req;
    logic                mem_ready;
    cache_pkg::word_t    mem_rdata;
    count_t              hits;
    count_t              misses;
    logic [3:0]          mem_delay = 4'd4;
    int                  log_errors;

    cache_pkg::word_t golden  [cache_pkg::addr_t]; // flat memory, keyed by word address
    cache_pkg::tag_t  m_tag   [cache_pkg::SETS][cache_pkg::WAYS];
    logic             m_valid [cache_pkg::SETS][cache_pkg::WAYS];
    logic             m_dirty [cache_pkg::SETS][cache_pkg::WAYS];
    int               m_age   [cache_pkg::SETS][cache_pkg::WAYS];
    cache_pkg::tag_t  tag_pool [6];
    cache_pkg::addr_t exp_wb_addr [$];
    cache_pkg::word_t exp_wb_data [$];
    cache_pkg::addr_t wb_addr [$];
    cache_pkg::word_t wb_data [$];
    count_t           exp_hits     = '0;
    count_t           exp_misses   = '0;
    count_t           ready_pulses = '0;
    int               n_done       = 0;
    int               n_checks     = 0;
    int               n_errors     = 0;

    cache_top #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) uut (
        .clk, .resetn,
        .cpu_valid, .cpu_req, .cpu_ready, .cpu_rdata,
        .mem_valid, .mem_req, .mem_ready, .mem_rdata,
        .hits, .misses
    );

    mem_model #(
        .FILL(FILL)
    ) mem (
        .clk, .resetn, .max_delay(mem_delay),
        .mem_valid, .mem_req, .mem_ready, .mem_rdata, .log_errors
    );

    initial forever #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (cpu_ready) begin
            ready_pulses <= ready_pulses + count_t'(1);
        end
        if (mem_valid && mem_ready && mem_req.write) begin // write-back log
            wb_addr.push_back(mem_req.addr);
            wb_data.push_back(mem_req.wdata);
        end
    end

    task automatic check_word(input string what, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input count_t got, input count_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic cache_pkg::word_t golden_read(cache_pkg::addr_t addr);
        cache_pkg::addr_t wa;
        wa = addr >> 2;
        if (golden.exists(wa)) return golden[wa];
        return wa ^ FILL;
    endfunction

    // returns the predicted hit and queues the predicted write-back words
    function automatic logic model_access(cache_pkg::addr_t addr, logic write);
        cache_pkg::index_t ix;
        cache_pkg::tag_t   tg;
        cache_pkg::addr_t  base;
        logic              hit;
        int                way;
        int                old;
        ix  = addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
        tg  = addr[31 -: cache_pkg::TAG_BITS];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (m_valid[ix][w] && m_tag[ix][w] == tg) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                if (m_age[ix][w] == cache_pkg::WAYS - 1) way = w; // oldest way
            end
            if (m_valid[ix][way] && m_dirty[ix][way]) begin
                for (int k = 0; k < cache_pkg::WORDS_PER_BLOCK; k++) begin
                    base = (cache_pkg::addr_t'({m_tag[ix][way], ix}) << cache_pkg::OFFSET_BITS)
                           + cache_pkg::addr_t'(4 * k);
                    exp_wb_addr.push_back(base);
                    exp_wb_data.push_back(golden_read(base));
                end
            end
            m_tag[ix][way]   = tg;
            m_valid[ix][way] = 1'b1;
            m_dirty[ix][way] = 1'b0;
        end
        old = m_age[ix][way];
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (w == way) m_age[ix][w] = 0;
            else if (m_age[ix][w] < old) m_age[ix][w]++;
        end
        if (write) m_dirty[ix][way] = 1'b1;
        return hit;
    endfunction

    function automatic cache_pkg::addr_t rand_addr();
        cache_pkg::tag_t      tg;
        cache_pkg::index_t    ix;
        cache_pkg::word_sel_t ws;
        tg = tag_pool[$urandom_range(5, 0)]; // 6 tags over 4 sets keeps sets full
        ix = cache_pkg::index_t'($urandom_range(3, 0));
        ws = cache_pkg::word_sel_t'($urandom_range(1, 0));
        return {tg, ix, ws, 2'b00};
    endfunction

    task automatic do_request(input cache_pkg::addr_t addr, input logic write,
                              input cache_pkg::word_t wdata);
        logic             pred_hit;
        cache_pkg::word_t expected;
        int               edges;
        int               n_wb;
        pred_hit = model_access(addr, write);
        expected = golden_read(addr);
        if (write) golden[addr >> 2] = wdata;
        @(posedge clk);
        cpu_valid     <= 1'b1;
        cpu_req.addr  <= addr;
        cpu_req.wdata <= wdata;
        cpu_req.write <= write;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!cpu_ready);
        cpu_valid <= 1'b0;
        n_done++;
        if (!write) check_word("read data", cpu_rdata, expected);
        if (pred_hit) check_count("hit latency", count_t'(edges - 1), count_t'(HIT_EDGES));
        n_wb = exp_wb_addr.size();
        check_count("write-back words", count_t'(wb_addr.size()), count_t'(n_wb));
        for (int i = 0; i < n_wb && i < wb_addr.size(); i++) begin
            check_addr("write-back address", wb_addr[i], exp_wb_addr[i]);
            check_word("write-back data", wb_data[i], exp_wb_data[i]);
        end
        wb_addr.delete();
        wb_data.delete();
        exp_wb_addr.delete();
        exp_wb_data.delete();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        @(negedge clk);
        check_count("hits", hits, exp_hits);
        check_count("misses", misses, exp_misses);
        check_count("ready pulses", ready_pulses, count_t'(n_done));
        check_count("write-back order errors", count_t'(log_errors), '0);
        $display("%s: %0d requests so far, %0d errors in this test",
                 name, n_done, n_errors - errors_before);
    endtask

    task automatic run_random(input string name, input int count);
        int               errors_before;
        logic             write;
        cache_pkg::addr_t addr;
        errors_before = n_errors;
        for (int i = 0; i < count; i++) begin
            addr  = rand_addr();
            write = $urandom_range(9, 0) < 4;
            do_request(addr, write, $urandom());
        end
        finish_test(name, errors_before);
    endtask

    task automatic run_repeat();
        int               errors_before;
        cache_pkg::addr_t addr;
        count_t           hits_before;
        errors_before = n_errors;
        for (int i = 0; i < N_REPEAT; i++) begin
            addr = rand_addr();
            do_request(addr, 1'($urandom_range(1, 0)), $urandom());
            hits_before = hits;
            do_request(addr, 1'($urandom_range(1, 0)), $urandom());
            check_count("repeat hits", hits - hits_before, count_t'(1));
        end
        finish_test("repeat", errors_before);
    endtask

    task automatic run_lru();
        int               errors_before;
        cache_pkg::addr_t addr;
        count_t           misses_before;
        errors_before = n_errors;
        misses_before = misses;
        // five tags in set 9, then the first again, which true LRU has evicted
        for (int k = 0; k <= 5; k++) begin
            addr = {cache_pkg::tag_t'(24'h80_0000 + k % 5), cache_pkg::index_t'(9), 3'b000};
            do_request(addr, k == 0, 32'hc0de_0000 + k);
        end
        check_count("lru misses", misses - misses_before, count_t'(6));
        finish_test("lru", errors_before);
    endtask

    initial begin
        void'($urandom(60124));
        for (int k = 0; k < 6; k++) tag_pool[k] = cache_pkg::tag_t'(4096 + 256 * k);
        for (int s = 0; s < cache_pkg::SETS; s++) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        run_random("random", N_RANDOM);
        run_repeat();
        run_lru();
        mem_delay <= 4'd10; // slow memory
        run_random("slow memory", N_SLOW);
        $display("requests %0d, checks %0d, errors %0d", n_done, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (N_REQ * 40 + 10));
        $display("timeout: the requests did not finish within %0d cycles", N_REQ * 40 + 10);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
